// ==== design/armCtrl_cfg.svh ====
`ifndef ARM_CTRL_CFG_SVH
`define ARM_CTRL_CFG_SVH

// ========================================
// Datapath widths seen by the controller
// ========================================

`define ARM_INSTR_W   32  // Instruction word
`define ARM_FLAGS_W   4   // NZCV

// ALU opcode field, instr[24:21]
`define ARM_ALUCTRL_W 4

`define ARM_MASK_W    4   // One enable per byte lane

`endif

// ==== design/armCtrlPkg.sv ====
`default_nettype none
`include "armCtrl_cfg.svh"

package armCtrlPkg;

  // Data-processing opcodes in instr[24:21] order
  typedef enum logic [`ARM_ALUCTRL_W-1:0] {
    opAnd, opEor, opSub, opRsb, opAdd, opAdc, opSbc, opRsc,
    opTst, opTeq, opCmp, opCmn, opOrr, opMov, opBic, opMvn
  } aluOp_t;

  // Condition field, instr[31:28]
  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt, condGt, condLe, condAl, condNv
  } cond_t;

  typedef struct packed {
    logic n;  // Bit 3, same order as CPSR[31:28]
    logic z;
    logic c;
    logic v;
  } flags_t;

  // ========================================
  // Per-stage control bundles
  // ========================================

  typedef struct packed {
    logic   aluSrc;      // Immediate operand B
    aluOp_t aluControl;
    logic   regWrite;
    logic   memWrite;
    logic   memtoReg;
    logic   branch;
    logic   pcSrc;       // Writes r15 or branches
    logic   flagWrite;   // S bit
    logic   noRegWrite;  // TST, TEQ, CMP, CMN
    logic   byteAccess;  // LDRB, STRB
    cond_t  cond;
  } ctrlE_t;

  typedef struct packed {
    logic                   memWrite;
    logic                   memtoReg;
    logic                   regWrite;
    logic                   pcSrc;
    logic [`ARM_MASK_W-1:0] byteMask;
    flags_t                 flagsNext;
    logic                   setFlags;  // flagsNext is newer than W copy
  } ctrlM_t;

  typedef struct packed {
    logic   memtoReg;
    logic   regWrite;
    logic   pcSrc;
    flags_t flagsNext;
    logic   setFlags;
  } ctrlW_t;

endpackage

`default_nettype wire

// ==== design/decodeIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// Decoded control from D to E
// No handshake, ctrl is valid every cycle
interface decodeIf;

  armCtrlPkg::ctrlE_t ctrl;  // Sampled by E register when not stalled

  // Decoder side
  modport dec (
    output ctrl
  );

  // Execute-stage side
  modport exe (
    input ctrl
  );

endinterface

`default_nettype wire

// ==== design/pipeReg.sv ====
`timescale 1ns/1ps
`default_nettype none

// Stage register shared by E, M and W
module pipeReg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rstN,
  input  logic     en,   // Low holds the stage
  input  logic     clr,  // Flush, beats en
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      q <= '0;
    end else if (clr) begin
      q <= '0;     // Bubble
    end else if (en) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// ==== design/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "armCtrl_cfg.svh"

module instrDecoder (
  input  logic [`ARM_INSTR_W-1:0] instr,
  output logic [1:0]              regSrc,  // [0] branch, [1] store
  output logic [1:0]              immSrc,  // 0 DP imm, 1 LDR/STR, 2 B
  output logic                    pcSrcD,
  decodeIf.dec                    dIf
);

  logic [2:0]         opClass;
  logic               isLoad;
  logic               extraSpace;
  logic               miscSpace;
  logic               isDp;
  logic               isLdSt;
  logic               isBranch;
  armCtrlPkg::cond_t  condD;
  armCtrlPkg::ctrlE_t ctrlD;

  // ========================================
  // Instruction class
  // ========================================

  assign opClass = instr[27:25];
  assign isLoad  = instr[20];  // L bit
  assign condD   = armCtrlPkg::cond_t'(instr[31:28]);

  // Multiply and halfword forms live in the DP register space
  assign extraSpace = ~instr[25] & instr[7] & instr[4];

  // Compare opcodes with S clear encode MSR, MRS and BX
  assign miscSpace = (instr[24:23] == 2'b10) & ~instr[20];

  assign isDp     = (opClass[2:1] == 2'b00) & ~extraSpace & ~miscSpace;
  assign isLdSt   = (opClass == 3'b010) | ((opClass == 3'b011) & ~instr[4]);  // 011 with bit 4 is undefined
  assign isBranch = (instr[27:24] == 4'b1010);  // B only, no link

  // ========================================
  // Main and ALU decoder
  // ========================================

  always_comb begin
    ctrlD  = '0;      // Unsupported encodings stay all zero
    regSrc = 2'b00;
    immSrc = 2'b00;
    if (isDp) begin
      ctrlD.aluSrc     = instr[25];  // I bit
      ctrlD.aluControl = armCtrlPkg::aluOp_t'(instr[24:21]);
      ctrlD.regWrite   = 1'b1;
      ctrlD.flagWrite  = instr[20];
      ctrlD.noRegWrite = (instr[24:23] == 2'b10);  // TST..CMN
      ctrlD.cond       = condD;
    end else if (isLdSt) begin
      ctrlD.aluSrc     = ~instr[25];  // I clear means 12-bit offset
      // U bit picks base plus or minus offset
      ctrlD.aluControl = instr[23] ? armCtrlPkg::opAdd : armCtrlPkg::opSub;
      ctrlD.regWrite   = isLoad;
      ctrlD.memWrite   = ~isLoad;
      ctrlD.memtoReg   = isLoad;
      ctrlD.byteAccess = instr[22];  // B bit
      ctrlD.cond       = condD;
      regSrc           = {~isLoad, 1'b0};  // Store reads Rd as data
      immSrc           = 2'b01;
    end else if (isBranch) begin
      ctrlD.aluSrc     = 1'b1;
      ctrlD.aluControl = armCtrlPkg::opAdd;  // PC plus offset
      ctrlD.branch     = 1'b1;
      ctrlD.cond       = condD;
      regSrc           = 2'b01;            // Rn is PC
      immSrc           = 2'b10;
    end
    // Write to r15 or branch redirects fetch
    ctrlD.pcSrc = (ctrlD.regWrite & ~ctrlD.noRegWrite & (instr[15:12] == 4'hF))
                | ctrlD.branch;
  end

  assign pcSrcD   = ctrlD.pcSrc;
  assign dIf.ctrl = ctrlD;

endmodule

`default_nettype wire

// ==== design/condCheck.sv ====
`timescale 1ns/1ps
`default_nettype none

module condCheck (
  input  armCtrlPkg::cond_t  cond,
  input  logic               flagWrite,
  input  armCtrlPkg::flags_t aluFlags,
  input  armCtrlPkg::flags_t flagsM,
  input  logic               setFlagsM,
  input  armCtrlPkg::flags_t flagsW,
  output logic               condEx,
  output armCtrlPkg::flags_t flagsNow,
  output armCtrlPkg::flags_t flagsNext,
  output logic               setFlags
);

  // M copy is newer whenever the instruction ahead set flags
  assign flagsNow = setFlagsM ? flagsM : flagsW;

  // ========================================
  // ARM condition table
  // ========================================

  always_comb begin
    unique case (cond)
      armCtrlPkg::condEq: condEx = flagsNow.z;
      armCtrlPkg::condNe: condEx = ~flagsNow.z;
      armCtrlPkg::condCs: condEx = flagsNow.c;
      armCtrlPkg::condCc: condEx = ~flagsNow.c;
      armCtrlPkg::condMi: condEx = flagsNow.n;
      armCtrlPkg::condPl: condEx = ~flagsNow.n;
      armCtrlPkg::condVs: condEx = flagsNow.v;
      armCtrlPkg::condVc: condEx = ~flagsNow.v;
      armCtrlPkg::condHi: condEx = flagsNow.c & ~flagsNow.z;  // Unsigned higher
      armCtrlPkg::condLs: condEx = ~flagsNow.c | flagsNow.z;
      armCtrlPkg::condGe: condEx = (flagsNow.n == flagsNow.v);  // Signed compares
      armCtrlPkg::condLt: condEx = (flagsNow.n != flagsNow.v);
      armCtrlPkg::condGt: condEx = ~flagsNow.z & (flagsNow.n == flagsNow.v);
      armCtrlPkg::condLe: condEx = flagsNow.z | (flagsNow.n != flagsNow.v);
      armCtrlPkg::condAl: condEx = 1'b1;
      default:            condEx = 1'b0;  // NV
    endcase
  end

  // Flag update only for S instructions that execute
  assign setFlags  = flagWrite & condEx;
  assign flagsNext = setFlags ? aluFlags : flagsNow;

endmodule

`default_nettype wire

// ==== design/byteLaneMask.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "armCtrl_cfg.svh"

// Lane 0 is the least significant byte of the word
module byteLaneMask (
  input  logic                   byteAccess,
  input  logic [1:0]             addrLow,
  output logic [`ARM_MASK_W-1:0] mask
);

  always_comb begin
    if (!byteAccess) begin
      mask = '1;  // Word
    end else begin
      unique case (addrLow)
        2'd0:    mask = 4'b0001;
        2'd1:    mask = 4'b0010;
        2'd2:    mask = 4'b0100;
        default: mask = 4'b1000;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/execCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "armCtrl_cfg.svh"

module execCtrl (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     stallE,
  input  logic                     flushE,
  decodeIf.exe                     eIf,
  input  logic                     pcSrcD,
  input  armCtrlPkg::flags_t       aluFlagsE,
  input  logic [1:0]               addrLowE,
  input  armCtrlPkg::ctrlM_t       ctrlMIn,     // Fed back from M
  input  armCtrlPkg::ctrlW_t       ctrlWIn,     // Fed back from W
  output logic                     aluSrcE,
  output logic [`ARM_ALUCTRL_W-1:0] aluControlE,
  output logic                     branchTakenE,
  output armCtrlPkg::flags_t       flagsE,
  output logic                     pcWrPendingF,
  output armCtrlPkg::ctrlM_t       ctrlMOut
);

  armCtrlPkg::ctrlE_t     ctrlE;
  logic                   condExE;
  logic                   memAccessE;
  logic [`ARM_MASK_W-1:0] laneMaskE;

  // ========================================
  // Execute register
  // ========================================

  pipeReg #(.payload_t(armCtrlPkg::ctrlE_t)) uRegE (
    .clk  (clk),
    .rstN (rstN),
    .en   (~stallE),
    .clr  (flushE),
    .d    (eIf.ctrl),
    .q    (ctrlE)
  );

  condCheck uCond (
    .cond      (ctrlE.cond),
    .flagWrite (ctrlE.flagWrite),
    .aluFlags  (aluFlagsE),
    .flagsM    (ctrlMIn.flagsNext),
    .setFlagsM (ctrlMIn.setFlags),
    .flagsW    (ctrlWIn.flagsNext),
    .condEx    (condExE),
    .flagsNow  (flagsE),
    .flagsNext (ctrlMOut.flagsNext),
    .setFlags  (ctrlMOut.setFlags)
  );

  byteLaneMask uMask (
    .byteAccess (ctrlE.byteAccess),
    .addrLow    (addrLowE),
    .mask       (laneMaskE)
  );

  assign memAccessE = ctrlE.memWrite | ctrlE.memtoReg;

  assign aluSrcE      = ctrlE.aluSrc;
  assign aluControlE  = ctrlE.aluControl;
  assign branchTakenE = ctrlE.branch & condExE;

  // Next M bundle, side effects gated by the condition
  assign ctrlMOut.memWrite = ctrlE.memWrite & condExE;
  assign ctrlMOut.memtoReg = ctrlE.memtoReg;
  assign ctrlMOut.regWrite = ctrlE.regWrite & condExE & ~ctrlE.noRegWrite;
  assign ctrlMOut.pcSrc    = ctrlE.pcSrc & condExE;
  assign ctrlMOut.byteMask = memAccessE ? laneMaskE : '0;  // Quiet unless memory op

  // Fetch waits while any PC write is in D, E or M
  assign pcWrPendingF = pcSrcD | ctrlE.pcSrc | ctrlMIn.pcSrc;

endmodule

`default_nettype wire

// ==== design/armController.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "armCtrl_cfg.svh"

module armController (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic [`ARM_INSTR_W-1:0]   instr,
  input  logic [`ARM_FLAGS_W-1:0]   aluFlagsE,
  input  logic [1:0]                addrLowE,
  input  logic                      stallE,
  input  logic                      flushE,
  input  logic                      stallM,
  input  logic                      stallW,
  input  logic                      flushW,
  output logic [1:0]                regSrcD,
  output logic [1:0]                immSrcD,
  output logic                      aluSrcE,
  output logic [`ARM_ALUCTRL_W-1:0] aluControlE,
  output logic                      branchTakenE,
  output logic [`ARM_FLAGS_W-1:0]   flagsE,
  output logic                      pcWrPendingF,
  output logic                      memWriteM,
  output logic                      memtoRegM,
  output logic                      regWriteM,
  output logic [`ARM_MASK_W-1:0]    byteMaskM,
  output logic                      memtoRegW,
  output logic                      regWriteW,
  output logic                      pcSrcW
);

  logic               pcSrcD;
  armCtrlPkg::ctrlM_t ctrlME;  // E output, M input
  armCtrlPkg::ctrlM_t ctrlM;
  armCtrlPkg::ctrlW_t ctrlWM;  // M output, W input
  armCtrlPkg::ctrlW_t ctrlW;

  decodeIf dIf ();

  // ========================================
  // Decode and execute
  // ========================================

  instrDecoder uDec (
    .instr  (instr),
    .regSrc (regSrcD),
    .immSrc (immSrcD),
    .pcSrcD (pcSrcD),
    .dIf    (dIf.dec)
  );

  execCtrl uExe (
    .clk          (clk),
    .rstN         (rstN),
    .stallE       (stallE),
    .flushE       (flushE),
    .eIf          (dIf.exe),
    .pcSrcD       (pcSrcD),
    .aluFlagsE    (aluFlagsE),
    .addrLowE     (addrLowE),
    .ctrlMIn      (ctrlM),
    .ctrlWIn      (ctrlW),
    .aluSrcE      (aluSrcE),
    .aluControlE  (aluControlE),
    .branchTakenE (branchTakenE),
    .flagsE       (flagsE),
    .pcWrPendingF (pcWrPendingF),
    .ctrlMOut     (ctrlME)
  );

  // ========================================
  // Memory and writeback registers
  // ========================================

  pipeReg #(.payload_t(armCtrlPkg::ctrlM_t)) uRegM (
    .clk  (clk),
    .rstN (rstN),
    .en   (~stallM),
    .clr  (1'b0),     // M is never flushed
    .d    (ctrlME),
    .q    (ctrlM)
  );

  assign ctrlWM.memtoReg  = ctrlM.memtoReg;
  assign ctrlWM.regWrite  = ctrlM.regWrite;
  assign ctrlWM.pcSrc     = ctrlM.pcSrc;
  assign ctrlWM.flagsNext = ctrlM.flagsNext;
  assign ctrlWM.setFlags  = ctrlM.setFlags;

  pipeReg #(.payload_t(armCtrlPkg::ctrlW_t)) uRegW (
    .clk  (clk),
    .rstN (rstN),
    .en   (~stallW),
    .clr  (flushW),
    .d    (ctrlWM),
    .q    (ctrlW)
  );

  assign memWriteM = ctrlM.memWrite;
  assign memtoRegM = ctrlM.memtoReg;
  assign regWriteM = ctrlM.regWrite;
  assign byteMaskM = ctrlM.byteMask;
  assign memtoRegW = ctrlW.memtoReg;
  assign regWriteW = ctrlW.regWrite;
  assign pcSrcW    = ctrlW.pcSrc;

endmodule

`default_nettype wire

// ==== testbench/tbClockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

// Free-running testbench clock
module tbClockGen #(
  parameter int periodNs = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(periodNs / 2) clk = ~clk;  // 50% duty

endmodule

`default_nettype wire

// ==== testbench/armControllerTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module armControllerTb;

  localparam logic [31:0] nopInstr = 32'hE1A0_0000;  // MOV r0, r0

  // Decoded control as the model sees it
  typedef struct packed {
    logic       aluSrc;
    logic [3:0] aluCtrl;
    logic       regWrite;
    logic       memWrite;
    logic       memtoReg;
    logic       branch;
    logic       pcSrc;
    logic       flagWrite;
    logic       noRegWrite;
    logic       byteAcc;
    logic [3:0] cond;
    logic [1:0] regSrc;
    logic [1:0] immSrc;
  } refDec_t;

  // Shadow stage layout shared by M and W
  typedef struct packed {
    logic       memWrite;
    logic       memtoReg;
    logic       regWrite;
    logic       pcSrc;
    logic [3:0] mask;
    logic [3:0] flags;
    logic       setFlags;
  } refStage_t;

  logic        clk;
  logic        rstN;
  logic [31:0] instr;
  logic [3:0]  aluFlagsE;
  logic [1:0]  addrLowE;
  logic        stallE;
  logic        flushE;
  logic        stallM;
  logic        stallW;
  logic        flushW;
  logic [1:0]  regSrcD;
  logic [1:0]  immSrcD;
  logic        aluSrcE;
  logic [3:0]  aluControlE;
  logic        branchTakenE;
  logic [3:0]  flagsE;
  logic        pcWrPendingF;
  logic        memWriteM;
  logic        memtoRegM;
  logic        regWriteM;
  logic [3:0]  byteMaskM;
  logic        memtoRegW;
  logic        regWriteW;
  logic        pcSrcW;

  logic [31:0] rngState;
  logic        checkOn;   // Assertions armed after first reset edge
  refDec_t     decD;
  refDec_t     refE;
  refStage_t   refM;
  refStage_t   refW;
  refStage_t   mNext;
  logic [3:0]  flagsNow;
  logic        passE;
  logic [3:0]  heldE;

  tbClockGen #(.periodNs(40)) uClk (.clk(clk));

  armController DUT (.*);

  // ========================================
  // Helpers
  // ========================================

  function automatic logic [31:0] nextRand();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return {rngState[15:0], rngState[31:16]};  // Low LCG bits are weak
  endfunction

  // Bit 4 stays clear to stay out of multiply and halfword space
  function automatic logic [31:0] dpRand(input logic [3:0] cond, input logic forceS);
    logic [31:0] r;
    logic        s;
    r = nextRand();
    s = forceS | r[20] | (r[24:23] == 2'b10);  // Compares need S set
    return {cond, 2'b00, r[25], r[24:21], s, r[19:5], 1'b0, r[3:0]};
  endfunction

  function automatic logic [31:0] memRand(input logic [3:0] cond);
    logic [31:0] r;
    r = nextRand();
    return {cond, 2'b01, r[25], 1'b1, r[23], r[22], 1'b0, r[20], r[19:5], 1'b0, r[3:0]};
  endfunction

  function automatic logic [31:0] brRand(input logic [3:0] cond);
    logic [31:0] r;
    r = nextRand();
    return {cond, 4'b1010, r[23:0]};
  endfunction

  function automatic logic [31:0] anyInstr();
    logic [31:0] r;
    r = nextRand();
    case (r[1:0])
      2'd2:    return memRand(r[7:4]);
      2'd3:    return brRand(r[7:4]);
      default: return dpRand(r[7:4], r[8]);
    endcase
  endfunction

  // ========================================
  // Reference model
  // ========================================

  function automatic refDec_t decodeRef(input logic [31:0] ins);
    refDec_t r;
    r = '0;
    if (ins[27:26] == 2'b00) begin          // Data processing
      r.aluSrc     = ins[25];
      r.aluCtrl    = ins[24:21];
      r.regWrite   = 1'b1;
      r.flagWrite  = ins[20];
      r.noRegWrite = (ins[24:21] >= 4'd8) && (ins[24:21] <= 4'd11);
      r.cond       = ins[31:28];
    end else if (ins[27:26] == 2'b01) begin // LDR, STR
      r.aluSrc   = ~ins[25];
      r.aluCtrl  = ins[23] ? 4'd4 : 4'd2;   // ADD or SUB
      r.regWrite = ins[20];
      r.memWrite = ~ins[20];
      r.memtoReg = ins[20];
      r.byteAcc  = ins[22];
      r.cond     = ins[31:28];
      r.regSrc   = {~ins[20], 1'b0};
      r.immSrc   = 2'd1;
    end else if (ins[27:24] == 4'b1010) begin
      r.aluSrc  = 1'b1;
      r.aluCtrl = 4'd4;
      r.branch  = 1'b1;
      r.cond    = ins[31:28];
      r.regSrc  = 2'b01;
      r.immSrc  = 2'd2;
    end
    r.pcSrc = r.branch | (r.regWrite & ~r.noRegWrite & (ins[15:12] == 4'hF));
    return r;
  endfunction

  function automatic logic condPass(input logic [3:0] cond, input logic [3:0] f);
    logic n;
    logic z;
    logic c;
    logic v;
    {n, z, c, v} = f;
    case (cond)
      4'h0:    return z;
      4'h1:    return !z;
      4'h2:    return c;
      4'h3:    return !c;
      4'h4:    return n;
      4'h5:    return !n;
      4'h6:    return v;
      4'h7:    return !v;
      4'h8:    return c && !z;
      4'h9:    return !c || z;
      4'hA:    return n == v;
      4'hB:    return n != v;
      4'hC:    return !z && (n == v);
      4'hD:    return z || (n != v);
      4'hE:    return 1'b1;
      default: return 1'b0;                 // NV
    endcase
  endfunction

  always_comb begin
    decD           = decodeRef(instr);
    flagsNow       = refM.setFlags ? refM.flags : refW.flags;  // Newest copy wins
    passE          = condPass(refE.cond, flagsNow);
    mNext.memWrite = refE.memWrite & passE;
    mNext.memtoReg = refE.memtoReg;
    mNext.regWrite = refE.regWrite & passE & ~refE.noRegWrite;
    mNext.pcSrc    = refE.pcSrc & passE;
    mNext.setFlags = refE.flagWrite & passE;
    mNext.flags    = mNext.setFlags ? aluFlagsE : flagsNow;
    if (!(refE.memWrite | refE.memtoReg)) begin
      mNext.mask = 4'h0;
    end else begin
      mNext.mask = refE.byteAcc ? (4'b0001 << addrLowE) : 4'hF;
    end
  end

  // Shadow pipeline E, M, W
  always @(posedge clk) begin
    if (!rstN) begin
      refE <= '0;
      refM <= '0;
      refW <= '0;
    end else begin
      if (flushE) begin
        refE <= '0;
      end else if (!stallE) begin
        refE <= decD;
      end
      if (!stallM) begin
        refM <= mNext;
      end
      if (flushW) begin
        refW <= '0;
      end else if (!stallW) begin
        refW <= refM;
      end
    end
  end

  // ========================================
  // Failure reporting
  // ========================================

  task automatic stopRun();
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic reportMismatch(input string sig, input logic [31:0] got,
                                input logic [31:0] expVal);
    $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", sig, got, expVal, $time);
    stopRun();
  endtask

  task automatic failPlain(input string what);
    $display("%s at %0t", what, $time);
    stopRun();
  endtask

  // ========================================
  // Output checks at the falling edge
  // ========================================

  assert property (@(negedge clk) disable iff (!checkOn) regSrcD == decD.regSrc)
    else reportMismatch("regSrcD", regSrcD, decD.regSrc);
  assert property (@(negedge clk) disable iff (!checkOn) immSrcD == decD.immSrc)
    else reportMismatch("immSrcD", immSrcD, decD.immSrc);
  assert property (@(negedge clk) disable iff (!checkOn) aluSrcE == refE.aluSrc)
    else reportMismatch("aluSrcE", aluSrcE, refE.aluSrc);
  assert property (@(negedge clk) disable iff (!checkOn) aluControlE == refE.aluCtrl)
    else reportMismatch("aluControlE", aluControlE, refE.aluCtrl);
  assert property (@(negedge clk) disable iff (!checkOn)
                   branchTakenE == (refE.branch & passE))
    else reportMismatch("branchTakenE", branchTakenE, refE.branch & passE);
  assert property (@(negedge clk) disable iff (!checkOn) flagsE == flagsNow)
    else reportMismatch("flagsE", flagsE, flagsNow);
  assert property (@(negedge clk) disable iff (!checkOn)
                   pcWrPendingF == (decD.pcSrc | refE.pcSrc | refM.pcSrc))
    else reportMismatch("pcWrPendingF", pcWrPendingF, decD.pcSrc | refE.pcSrc | refM.pcSrc);
  assert property (@(negedge clk) disable iff (!checkOn) memWriteM == refM.memWrite)
    else reportMismatch("memWriteM", memWriteM, refM.memWrite);
  assert property (@(negedge clk) disable iff (!checkOn) memtoRegM == refM.memtoReg)
    else reportMismatch("memtoRegM", memtoRegM, refM.memtoReg);
  assert property (@(negedge clk) disable iff (!checkOn) regWriteM == refM.regWrite)
    else reportMismatch("regWriteM", regWriteM, refM.regWrite);
  assert property (@(negedge clk) disable iff (!checkOn) byteMaskM == refM.mask)
    else reportMismatch("byteMaskM", byteMaskM, refM.mask);
  assert property (@(negedge clk) disable iff (!checkOn) memtoRegW == refW.memtoReg)
    else reportMismatch("memtoRegW", memtoRegW, refW.memtoReg);
  assert property (@(negedge clk) disable iff (!checkOn) regWriteW == refW.regWrite)
    else reportMismatch("regWriteW", regWriteW, refW.regWrite);
  assert property (@(negedge clk) disable iff (!checkOn) pcSrcW == refW.pcSrc)
    else reportMismatch("pcSrcW", pcSrcW, refW.pcSrc);

  // ========================================
  // Stimulus
  // ========================================

  // New instruction and E-stage datapath inputs after each edge
  task automatic driveCycle(input logic [31:0] ins);
    logic [31:0] r;
    @(posedge clk);
    #2;
    r         = nextRand();
    instr     = ins;
    aluFlagsE = r[3:0];
    addrLowE  = r[5:4];
  endtask

  task automatic checkIdle(input string when);
    @(negedge clk);
    assert ({aluSrcE, aluControlE, branchTakenE, flagsE, pcWrPendingF, memWriteM,
             memtoRegM, regWriteM, byteMaskM, memtoRegW, regWriteW, pcSrcW} === '0)
      else failPlain({"control outputs not idle ", when});
  endtask

  task automatic waitPcSrcW(input int maxCycles);
    int n;
    n = 0;
    @(negedge clk);
    while (!pcSrcW && n < maxCycles) begin
      @(negedge clk);
      n++;
    end
    if (!pcSrcW) failPlain("pcSrcW never rose after a taken branch");
  endtask

  initial begin
    logic [31:0] r;
    rngState  = 32'd98956;
    rstN      = 1'b0;
    checkOn   = 1'b0;
    instr     = '0;
    aluFlagsE = '0;
    addrLowE  = '0;
    stallE    = 1'b0;
    flushE    = 1'b0;
    stallM    = 1'b0;
    stallW    = 1'b0;
    flushW    = 1'b0;

    // Reset held across 10 edges
    @(posedge clk);
    #1 checkOn = 1'b1;
    repeat (4) @(posedge clk);
    checkIdle("during reset");
    repeat (5) @(posedge clk);
    #2 rstN = 1'b1;
    checkIdle("right after reset");

    repeat (40) driveCycle(dpRand(4'hE, 1'b0));  // DP under AL

    // Flag producers followed by conditional consumers
    repeat (40) begin
      driveCycle(dpRand(4'hE, 1'b1));
      r = nextRand();
      driveCycle(dpRand(r[3:0], 1'b0));
    end

    repeat (40) driveCycle(memRand(4'hE));

    // Taken branch through to W
    repeat (3) driveCycle(nopInstr);
    driveCycle(brRand(4'hE));
    driveCycle(nopInstr);
    waitPcSrcW(6);
    repeat (20) begin
      driveCycle(dpRand(4'hE, 1'b1));
      r = nextRand();
      driveCycle(brRand(r[3:0]));
    end

    // E stall holds the decoded bundle
    driveCycle(dpRand(4'hE, 1'b0));
    driveCycle(dpRand(4'hE, 1'b0));
    stallE = 1'b1;
    @(negedge clk);
    heldE = aluControlE;
    repeat (3) begin
      driveCycle(anyInstr());
      @(negedge clk);
      assert (aluControlE == heldE) else failPlain("E stage moved while stallE was high");
    end

    // Flush pulse on E and the bubble it leaves in M
    driveCycle(memRand(4'hE));
    stallE = 1'b0;
    flushE = 1'b1;
    driveCycle(memRand(4'hE));
    flushE = 1'b0;
    @(negedge clk);
    assert ({aluSrcE, aluControlE, branchTakenE} == '0)
      else failPlain("E outputs not cleared by flushE");
    driveCycle(nopInstr);
    @(negedge clk);
    assert ({memWriteM, memtoRegM, regWriteM, byteMaskM} == '0)
      else failPlain("M outputs not cleared behind an E flush");

    // W flush while a load sits in M
    driveCycle(memRand(4'hE) | 32'h0010_0000);  // L bit set
    repeat (2) driveCycle(nopInstr);
    flushW = 1'b1;
    driveCycle(nopInstr);
    flushW = 1'b0;
    @(negedge clk);
    assert ({memtoRegW, regWriteW, pcSrcW} == '0)
      else failPlain("W outputs not cleared by flushW");

    // Mixed traffic with sparse stalls and flushes
    repeat (80) begin
      driveCycle(anyInstr());
      r      = nextRand();
      stallE = (r[2:0] == 3'd0);
      flushE = (r[5:3] == 3'd0);
      stallM = (r[8:6] == 3'd0);
      stallW = (r[11:9] == 3'd0);
      flushW = (r[14:12] == 3'd0);
    end
    stallE = 1'b0;
    flushE = 1'b0;
    stallM = 1'b0;
    stallW = 1'b0;
    flushW = 1'b0;
    repeat (4) driveCycle(nopInstr);   // Drain
    @(negedge clk);

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== armController.f ====
+incdir+design
design/armCtrlPkg.sv
design/decodeIf.sv
design/pipeReg.sv
design/instrDecoder.sv
design/condCheck.sv
design/byteLaneMask.sv
design/execCtrl.sv
design/armController.sv
testbench/tbClockGen.sv
testbench/armControllerTb.sv

// ==== Bender.yml ====
package:
  name: armController

sources:
  - include_dirs:
      - design
    files:
      - design/armCtrlPkg.sv
      - design/decodeIf.sv
      - design/pipeReg.sv
      - design/instrDecoder.sv
      - design/condCheck.sv
      - design/byteLaneMask.sv
      - design/execCtrl.sv
      - design/armController.sv
  - target: test
    files:
      - testbench/tbClockGen.sv
      - testbench/armControllerTb.sv
